// File: logic/musicBoxPkg.sv
// Music box user-side types
// Key count, key vector, user control bundle and box state encoding

package musicBoxPkg;

	//----------------------------------------------------------------------
	// Keys
	//----------------------------------------------------------------------
	localparam int NumKeys = 6; // Music keys on the board

	// One bit per key, set bit means sounding
	typedef logic [NumKeys-1:0] keyVector;

	//----------------------------------------------------------------------
	// User inputs
	//----------------------------------------------------------------------
	// All fields active low, raw from pins or after smoothing
	typedef struct packed {
		keyVector musicKeys_n;     // Music keys
		logic     makeRecording_n; // Start/stop recording button
		logic     playRecording_n; // Replay button
	} userControls;

	//----------------------------------------------------------------------
	// Controller state
	//----------------------------------------------------------------------
	typedef enum logic [1:0] {
		Idle      = 2'd0, // Live play
		Recording = 2'd1, // Live play, keys stored per frame
		Playback  = 2'd2  // Keys come from memory
	} boxState;

endpackage

// File: logic/dacPkg.sv
// SPI DAC types
// Frame length, sample code, power-down modes and the frame union

package dacPkg;

	localparam int FrameBits = 16; // Bits per SPI transfer

	// Unsigned DAC code
	typedef logic [11:0] dacSample;

	// Power-down control bits of the DAC frame
	typedef enum logic [1:0] {
		NormalOperation = 2'b00,
		PowerDown1k     = 2'b01, // Output to ground through 1k
		PowerDown100k   = 2'b10, // Output to ground through 100k
		PowerDownOpen   = 2'b11  // Output high impedance
	} powerDownMode;

	// One transfer word, filled by field and shifted out raw
	typedef union packed {
		logic [FrameBits-1:0] raw; // Shift view, MSB goes first
		struct packed {
			logic [1:0]   reserved; // Always zero
			powerDownMode mode;
			dacSample     sample;
		} fields;
	} dacFrame;

endpackage

// File: logic/triggerSmoother.sv
// Input conditioning for all active-low user controls
// Two-flop synchronizer plus stability counter per bit

`timescale 1ns/1ps

module triggerSmoother #(
	parameter int SmoothCycles = 4 // Clocks an input must hold before it is taken
) (
	input  logic                    CLK_100hz,
	input  logic                    systemReset_n,
	input  musicBoxPkg::userControls rawControls,
	output musicBoxPkg::userControls smoothControls
);
	import musicBoxPkg::*;

	localparam int ControlBits = $bits(userControls);
	localparam int CountBits   = $clog2(SmoothCycles + 1);

	logic [ControlBits-1:0] rawBits;
	logic [ControlBits-1:0] syncFirst;   // Metastability stage
	logic [ControlBits-1:0] syncSecond;  // Safe to use
	logic [ControlBits-1:0] smoothBits;  // Accepted levels
	logic [CountBits-1:0]   stableCount [ControlBits];

	assign rawBits = rawControls;

	//----------------------------------------------------------------------
	// Per-bit filter
	//----------------------------------------------------------------------
	always_ff @(posedge CLK_100hz or negedge systemReset_n) begin
		if (!systemReset_n) begin
			syncFirst  <= '1; // Everything released
			syncSecond <= '1;
			smoothBits <= '1;
			for (int i = 0; i < ControlBits; i++) begin
				stableCount[i] <= '0;
			end
		end else begin
			syncFirst  <= rawBits;
			syncSecond <= syncFirst;
			for (int i = 0; i < ControlBits; i++) begin
				if (syncSecond[i] == smoothBits[i]) begin
					stableCount[i] <= '0; // Back to accepted level, start over
				end else if (stableCount[i] == CountBits'(SmoothCycles - 1)) begin
					smoothBits[i]  <= syncSecond[i]; // Held long enough
					stableCount[i] <= '0;
				end else begin
					stableCount[i] <= stableCount[i] + 1'b1;
				end
			end
		end
	end

	assign smoothControls = userControls'(smoothBits);

endmodule

// File: logic/musicBoxStateController.sv
// Box mode FSM: Idle, Recording, Playback
// Moves on registered button press edges, recorder full and replay done

`timescale 1ns/1ps

module musicBoxStateController (
	input  logic                 CLK_100hz,
	input  logic                 systemReset_n,
	input  logic                 makeRecording_n, // Smoothed, active low
	input  logic                 playRecording_n, // Smoothed, active low
	input  logic                 recordFull,      // Recorder out of space
	input  logic                 playDone,        // Last entry replayed
	output musicBoxPkg::boxState currentState
);
	import musicBoxPkg::*;

	logic makeLast_n;   // Button levels one clock back
	logic playLast_n;
	logic makePress;    // Registered falling edges
	logic playPress;
	boxState nextState;

	//----------------------------------------------------------------------
	// Press detection
	//----------------------------------------------------------------------
	always_ff @(posedge CLK_100hz or negedge systemReset_n) begin
		if (!systemReset_n) begin
			makeLast_n <= 1'b1;
			playLast_n <= 1'b1;
			makePress  <= 1'b0;
			playPress  <= 1'b0;
		end else begin
			makeLast_n <= makeRecording_n;
			playLast_n <= playRecording_n;
			makePress  <= makeLast_n & ~makeRecording_n; // High to low
			playPress  <= playLast_n & ~playRecording_n;
		end
	end

	//----------------------------------------------------------------------
	// State machine
	//----------------------------------------------------------------------
	always_comb begin
		nextState = currentState; // Other presses ignored
		case (currentState)
			Idle: begin
				if (makePress) nextState = Recording;
				else if (playPress) nextState = Playback;
			end
			Recording: if (makePress || recordFull) nextState = Idle; // Stop or memory full
			Playback:  if (playDone) nextState = Idle;
			default:   nextState = Idle;
		endcase
	end

	always_ff @(posedge CLK_100hz or negedge systemReset_n) begin
		if (!systemReset_n) currentState <= Idle;
		else currentState <= nextState;
	end

	// Only the three defined encodings ever show up
	stateLegal: assert property (@(posedge CLK_100hz) disable iff (!systemReset_n)
		currentState inside {Idle, Recording, Playback})
		else $error("Illegal box state %0d", currentState);

endmodule

// File: logic/keyRecorder.sv
// Key snapshot memory
// Records the active keys once per frame, replays them, picks live or stored keys

`timescale 1ns/1ps

module keyRecorder #(
	parameter int RecordDepth = 16 // Frames of keys that fit in memory
) (
	input  logic                  CLK_100hz,
	input  logic                  systemReset_n,
	input  musicBoxPkg::boxState  currentState,
	input  musicBoxPkg::keyVector liveKeys_n,   // Smoothed, active low
	input  logic                  frameTick,    // One pulse per sample frame
	output musicBoxPkg::keyVector activeKeys,   // Keys that sound now
	output logic                  recordFull,
	output logic                  playDone      // One-cycle pulse
);
	import musicBoxPkg::*;

	localparam int AddrBits = $clog2(RecordDepth);
	localparam int LenBits  = $clog2(RecordDepth + 1); // Must hold RecordDepth itself

	keyVector            keyMemory [RecordDepth];
	logic [LenBits-1:0]  writePtr;
	logic [LenBits-1:0]  storedLength;  // Entries of last recording
	logic [LenBits-1:0]  readPtr;
	keyVector            playKeys;      // Entry being replayed
	keyVector            liveKeys;
	logic                writeNow;

	assign liveKeys   = ~liveKeys_n; // Pins are active low
	assign recordFull = (writePtr == LenBits'(RecordDepth));
	assign writeNow   = (currentState == Recording) && frameTick && !recordFull;

	// Snapshot storage
	always_ff @(posedge CLK_100hz) begin
		if (writeNow) keyMemory[writePtr[AddrBits-1:0]] <= liveKeys;
	end

	//----------------------------------------------------------------------
	// Pointers and replay
	//----------------------------------------------------------------------
	always_ff @(posedge CLK_100hz or negedge systemReset_n) begin
		if (!systemReset_n) begin
			writePtr     <= '0;
			storedLength <= '0; // Nothing recorded yet
			readPtr      <= '0;
			playKeys     <= '0;
			playDone     <= 1'b0;
		end else begin
			playDone <= 1'b0;
			if (currentState == Recording) begin
				if (writeNow) writePtr <= writePtr + 1'b1;
				storedLength <= writePtr + LenBits'(writeNow); // Counts this write too
			end else begin
				writePtr <= '0; // Next recording starts at entry 0
			end

			if (currentState != Playback) begin
				readPtr  <= '0;
				playKeys <= '0;
			end else if (frameTick) begin
				if (readPtr == storedLength) begin
					playDone <= 1'b1; // Last entry had its frame
					playKeys <= '0;
				end else begin
					playKeys <= keyMemory[readPtr[AddrBits-1:0]];
					readPtr  <= readPtr + 1'b1;
				end
			end
		end
	end

	assign activeKeys = (currentState == Playback) ? playKeys : liveKeys;

	// Write pointer stays inside the memory range
	writeInRange: assert property (@(posedge CLK_100hz) disable iff (!systemReset_n)
		writePtr <= LenBits'(RecordDepth))
		else $error("Write pointer %0d past depth", writePtr);

endmodule

// File: logic/toneSampleGenerator.sv
// Sample frame pacing and square-wave tone sum
// Builds one DAC frame per frame tick from the sounding keys

`timescale 1ns/1ps

module toneSampleGenerator #(
	parameter int SamplePeriod = 40,  // Clocks per frame, above the SPI frame length
	parameter int KeyLevel     = 682  // Code added per high key
) (
	input  logic                  CLK_100hz,
	input  logic                  systemReset_n,
	input  musicBoxPkg::keyVector activeKeys,
	output logic                  frameTick,    // One pulse per frame
	output dacPkg::dacFrame       frame,
	output logic                  sendSample_n  // Start strobe to the serializer
);
	import musicBoxPkg::*;
	import dacPkg::*;

	localparam int PeriodBits    = $clog2(SamplePeriod);
	localparam int PatternFrames = 120; // LCM of all six key periods
	localparam int IndexBits     = $clog2(PatternFrames);
	localparam int PhaseBits     = $clog2(NumKeys);
	localparam int CountBits     = $clog2(NumKeys + 1);

	logic [PeriodBits-1:0] periodCount;
	logic                  periodEnd;
	logic [IndexBits-1:0]  frameIndex;
	logic [PhaseBits-1:0]  phaseCount [NumKeys]; // Frames into current half period
	keyVector              phaseHigh;            // Square wave level per key
	logic [CountBits-1:0]  soundingCount;
	dacFrame               frameNext;

	assign periodEnd = (periodCount == PeriodBits'(SamplePeriod - 1));

	// Keys pressed and in their high half
	always_comb begin
		soundingCount = '0;
		for (int k = 0; k < NumKeys; k++) begin
			soundingCount = soundingCount + CountBits'(activeKeys[k] & phaseHigh[k]);
		end
		frameNext.fields.reserved = '0;
		frameNext.fields.mode     = NormalOperation;
		frameNext.fields.sample   = dacSample'(soundingCount * KeyLevel);
	end

	//----------------------------------------------------------------------
	// Frame pacing and phases
	//----------------------------------------------------------------------
	always_ff @(posedge CLK_100hz or negedge systemReset_n) begin
		if (!systemReset_n) begin
			periodCount <= '0;
			frameTick   <= 1'b0;
			frameIndex  <= '0;
			phaseHigh   <= '1; // Every key starts high
			for (int k = 0; k < NumKeys; k++) phaseCount[k] <= '0;
		end else begin
			frameTick <= periodEnd;
			if (periodEnd) begin
				periodCount <= '0;
				if (frameIndex == IndexBits'(PatternFrames - 1)) begin
					frameIndex <= '0; // Whole pattern repeats here
					phaseHigh  <= '1;
					for (int k = 0; k < NumKeys; k++) phaseCount[k] <= '0;
				end else begin
					frameIndex <= frameIndex + 1'b1;
					for (int k = 0; k < NumKeys; k++) begin
						if (phaseCount[k] == PhaseBits'(k)) begin
							phaseCount[k] <= '0;   // Key k holds k+1 frames
							phaseHigh[k]  <= ~phaseHigh[k];
						end else begin
							phaseCount[k] <= phaseCount[k] + 1'b1;
						end
					end
				end
			end else begin
				periodCount <= periodCount + 1'b1;
			end
		end
	end

	// Keys latched into the sample at frame end
	always_ff @(posedge CLK_100hz) begin
		if (periodEnd) frame <= frameNext;
	end

	assign sendSample_n = ~frameTick; // Strobe low with the tick

endmodule

// File: logic/spiDacSerializer.sv
// SPI transmitter for one 16-bit DAC frame
// SYNC_n framing, two clocks per bit, MSB first

`timescale 1ns/1ps

module spiDacSerializer (
	input  logic            CLK_100hz,
	input  logic            systemReset_n,
	input  dacPkg::dacFrame frame,
	input  logic            sendSample_n,     // Start strobe, active low
	output logic            spiSclk,
	output logic            spiSync_n,        // Low for the whole transfer
	output logic            spiDin,
	output logic            isBusy,
	output logic            transmitComplete  // One-cycle pulse at the end
);
	import dacPkg::*;

	localparam int BitBits = $clog2(FrameBits);

	dacFrame             shiftReg;   // Bits still to send, next one at MSB
	logic [BitBits-1:0]  bitCount;   // Bit in flight
	logic                loadFrame;
	logic                nextBit;
	logic                lastBit;

	assign loadFrame = !sendSample_n && !isBusy; // Strobe while busy is lost
	assign lastBit   = (bitCount == BitBits'(FrameBits - 1));
	assign nextBit   = isBusy && !spiSclk && !lastBit; // End of a low phase

	// Shift register on the raw view
	always_ff @(posedge CLK_100hz) begin
		if (loadFrame) shiftReg.raw <= frame.raw << 1; // MSB already on DIN
		else if (nextBit) shiftReg.raw <= shiftReg.raw << 1;
	end

	//----------------------------------------------------------------------
	// Transfer control
	//----------------------------------------------------------------------
	always_ff @(posedge CLK_100hz or negedge systemReset_n) begin
		if (!systemReset_n) begin
			spiSclk          <= 1'b0;
			spiSync_n        <= 1'b1;
			spiDin           <= 1'b0;
			isBusy           <= 1'b0;
			transmitComplete <= 1'b0;
			bitCount         <= '0;
		end else begin
			transmitComplete <= 1'b0;
			if (loadFrame) begin
				spiSync_n <= 1'b0;
				isBusy    <= 1'b1;
				spiSclk   <= 1'b1; // High phase of first bit
				spiDin    <= frame.raw[FrameBits-1];
				bitCount  <= '0;
			end else if (isBusy) begin
				if (spiSclk) begin
					spiSclk <= 1'b0; // DAC samples on this fall
				end else if (lastBit) begin
					spiSync_n        <= 1'b1; // 32 clocks done
					isBusy           <= 1'b0;
					spiDin           <= 1'b0;
					transmitComplete <= 1'b1;
				end else begin
					spiSclk  <= 1'b1;
					spiDin   <= shiftReg.raw[FrameBits-1];
					bitCount <= bitCount + 1'b1;
				end
			end
		end
	end

	// SYNC_n never low outside a transfer
	syncIdle: assert property (@(posedge CLK_100hz) disable iff (!systemReset_n)
		!isBusy |-> spiSync_n)
		else $error("SYNC_n low while serializer idle");

endmodule

// File: logic/musicBoxMain.sv
// Music box top level
// Smoother, mode FSM, key recorder, tone generator and DAC serializer

`timescale 1ns/1ps

module musicBoxMain #(
	parameter int SmoothCycles = 4,   // Input filter length
	parameter int RecordDepth  = 16,  // Recorded frames
	parameter int SamplePeriod = 40,  // Clocks per frame, above 34
	parameter int KeyLevel     = 682  // Code per sounding key, six keys fit 12 bits
) (
	input  logic                     CLK_100hz,
	input  logic                     systemReset_n,
	input  musicBoxPkg::userControls rawControls,   // Straight from the pins
	output logic                     spiSclk,
	output logic                     spiSync_n,
	output logic                     spiDin,
	output musicBoxPkg::boxState     currentState,  // For the LEDs
	output musicBoxPkg::keyVector    activeKeys,    // For the LEDs
	output logic                     dacBusy
);
	import musicBoxPkg::*;
	import dacPkg::*;

	userControls smoothControls;
	logic        recordFull;
	logic        playDone;
	logic        frameTick;
	dacFrame     sampleFrame;
	logic        sendSample_n;

	//----------------------------------------------------------------------
	// User side
	//----------------------------------------------------------------------
	triggerSmoother #(.SmoothCycles(SmoothCycles)) i_triggerSmoother (
		.CLK_100hz     (CLK_100hz),
		.systemReset_n (systemReset_n),
		.rawControls   (rawControls),
		.smoothControls(smoothControls)
	);

	musicBoxStateController i_stateController (
		.CLK_100hz      (CLK_100hz),
		.systemReset_n  (systemReset_n),
		.makeRecording_n(smoothControls.makeRecording_n),
		.playRecording_n(smoothControls.playRecording_n),
		.recordFull     (recordFull),
		.playDone       (playDone),
		.currentState   (currentState)
	);

	keyRecorder #(.RecordDepth(RecordDepth)) i_keyRecorder (
		.CLK_100hz    (CLK_100hz),
		.systemReset_n(systemReset_n),
		.currentState (currentState),
		.liveKeys_n   (smoothControls.musicKeys_n),
		.frameTick    (frameTick),
		.activeKeys   (activeKeys),
		.recordFull   (recordFull),
		.playDone     (playDone)
	);

	//----------------------------------------------------------------------
	// Audio out
	//----------------------------------------------------------------------
	toneSampleGenerator #(.SamplePeriod(SamplePeriod), .KeyLevel(KeyLevel)) i_toneGenerator (
		.CLK_100hz    (CLK_100hz),
		.systemReset_n(systemReset_n),
		.activeKeys   (activeKeys),
		.frameTick    (frameTick),
		.frame        (sampleFrame),
		.sendSample_n (sendSample_n)
	);

	spiDacSerializer i_dacSerializer (
		.CLK_100hz       (CLK_100hz),
		.systemReset_n   (systemReset_n),
		.frame           (sampleFrame),
		.sendSample_n    (sendSample_n),
		.spiSclk         (spiSclk),
		.spiSync_n       (spiSync_n),
		.spiDin          (spiDin),
		.isBusy          (dacBusy),
		.transmitComplete()  // Nothing waits on the end of a transfer
	);

endmodule

// File: bench/musicBoxBench.sv
// Testbench for the music box top level
// Clock, reset, key and button stimulus, SPI frame decoder, reference model,
// compare tasks, record/replay checks and watchdog

`timescale 1ns/1ps

module musicBoxBench;
	import musicBoxPkg::*;
	import dacPkg::*;

	localparam int SmoothCycles  = 4;
	localparam int RecordDepth   = 16;
	localparam int SamplePeriod  = 40;
	localparam int KeyLevel      = 682;
	localparam int ClockPeriod   = 40;   // ns
	localparam int ResetCycles   = 8;
	localparam int DriveDelay    = 1;    // ns after the rising edge
	localparam int PressCycles   = 3 * SmoothCycles;
	localparam int LivePatterns  = 6;
	localparam int WatchdogTime  = 300 * SamplePeriod * ClockPeriod;
	localparam logic [31:0] RandomSeed = 32'h86c;

	// One decoded SPI transfer plus what was seen at its start strobe
	typedef struct packed {
		dacFrame    frame;
		keyVector   keys;
		boxState    state;
		logic [7:0] bits;
	} decodedFrame;

	logic        CLK_100hz = 1'b0;
	logic        systemReset_n = 1'b0;
	userControls rawControls = '1;   // Everything released
	logic        spiSclk;
	logic        spiSync_n;
	logic        spiDin;
	boxState     currentState;
	keyVector    activeKeys;
	logic        dacBusy;

	int          errorCount = 0;
	int          checkTotal = 0;
	int          framesChecked = 0;     // Also the frame index of the next frame
	decodedFrame frameQueue[$];
	keyVector    recordLog[$];          // Keys at strobes while Recording
	keyVector    playLog[$];            // Keys at strobes while Playback
	event        frameDecoded;

	musicBoxMain #(
		.SmoothCycles(SmoothCycles),
		.RecordDepth (RecordDepth),
		.SamplePeriod(SamplePeriod),
		.KeyLevel    (KeyLevel)
	) i_dut (
		.CLK_100hz    (CLK_100hz),
		.systemReset_n(systemReset_n),
		.rawControls  (rawControls),
		.spiSclk      (spiSclk),
		.spiSync_n    (spiSync_n),
		.spiDin       (spiDin),
		.currentState (currentState),
		.activeKeys   (activeKeys),
		.dacBusy      (dacBusy)
	);

	always #(ClockPeriod / 2) CLK_100hz = ~CLK_100hz;

	//----------------------------------------------------------------------
	// Reference model
	//----------------------------------------------------------------------
	// Key k sounds high while floor(frame/(k+1)) is even
	function automatic dacSample expectedSample(input int frameIndex, input keyVector keys);
		int highKeys;
		highKeys = 0;
		for (int k = 0; k < NumKeys; k++) begin
			if (keys[k] && ((frameIndex / (k + 1)) % 2 == 0)) highKeys++;
		end
		return dacSample'(highKeys * KeyLevel);
	endfunction

	function automatic dacFrame expectedFrame(input int frameIndex, input keyVector keys);
		dacFrame result;
		result.fields.reserved = 2'b00;
		result.fields.mode     = NormalOperation;
		result.fields.sample   = expectedSample(frameIndex, keys);
		return result;
	endfunction

	//----------------------------------------------------------------------
	// Compare tasks
	//----------------------------------------------------------------------
	task automatic checkFrame(input string name, input dacFrame got, input dacFrame expected);
		checkTotal++;
		if (got.raw !== expected.raw) begin
			errorCount++;
			$display("Error at %0t ns: %s got %h expected %h", $time, name, got.raw,
				expected.raw);
		end
	endtask

	task automatic checkKeys(input string name, input keyVector got, input keyVector expected);
		checkTotal++;
		if (got !== expected) begin
			errorCount++;
			$display("Error at %0t ns: %s got %b expected %b", $time, name, got, expected);
		end
	endtask

	task automatic checkState(input string name, input boxState got, input boxState expected);
		checkTotal++;
		if (got !== expected) begin
			errorCount++;
			$display("Error at %0t ns: %s got %s expected %s", $time, name, got.name(),
				expected.name());
		end
	endtask

	task automatic checkCount(input string name, input int got, input int expected);
		checkTotal++;
		if (got != expected) begin
			errorCount++;
			$display("Error at %0t ns: %s got %0d expected %0d", $time, name, got, expected);
		end
	endtask

	task automatic checkLevel(input string name, input logic got, input logic expected);
		checkTotal++;
		if (got !== expected) begin
			errorCount++;
			$display("Error at %0t ns: %s got %b expected %b", $time, name, got, expected);
		end
	endtask

	//----------------------------------------------------------------------
	// SPI decoder sampled mid-cycle where pins are stable
	//----------------------------------------------------------------------
	logic                 lastSync = 1'b1;
	logic                 lastSclk = 1'b0;
	keyVector             prevKeys = '0;   // Keys in the strobe cycle
	boxState              prevState = Idle;
	keyVector             startKeys;
	boxState              startState;
	logic [FrameBits-1:0] shiftIn;
	int                   bitsIn = 0;
	decodedFrame          entry;

	always @(negedge CLK_100hz) begin
		if (systemReset_n) begin
			if (!spiSync_n && lastSync) begin // SYNC_n fell
				shiftIn    = '0;
				bitsIn     = 0;
				startKeys  = prevKeys;
				startState = prevState;
			end
			if (!spiSync_n && lastSclk && !spiSclk) begin // SCLK fell, DAC takes DIN
				shiftIn = {shiftIn[FrameBits-2:0], spiDin};
				bitsIn++;
			end
			if (spiSync_n && !lastSync) begin // SYNC_n rose, frame over
				entry.frame.raw = shiftIn;
				entry.keys      = startKeys;
				entry.state     = startState;
				entry.bits      = 8'(bitsIn);
				frameQueue.push_back(entry);
				-> frameDecoded;
			end
		end
		lastSync  = spiSync_n;
		lastSclk  = spiSclk;
		prevKeys  = activeKeys;
		prevState = currentState;
	end

	// Compare every decoded frame with the reference
	initial begin
		decodedFrame got;
		forever begin
			@(frameDecoded);
			while (frameQueue.size() > 0) begin
				got = frameQueue.pop_front();
				checkCount("frame bits", got.bits, FrameBits);
				checkFrame("DAC frame", got.frame, expectedFrame(framesChecked, got.keys));
				if (got.state == Recording) recordLog.push_back(got.keys);
				else if (got.state == Playback) playLog.push_back(got.keys);
				framesChecked++;
			end
		end
	end

	//----------------------------------------------------------------------
	// Stimulus helpers
	//----------------------------------------------------------------------
	// Returns just after the first edge of a new SPI transfer
	task automatic waitFrameStart();
		@(negedge spiSync_n);
		@(posedge CLK_100hz);
		#DriveDelay;
	endtask

	task automatic pressButton(input logic isMake);
		waitFrameStart();
		if (isMake) rawControls.makeRecording_n = 1'b0;
		else rawControls.playRecording_n = 1'b0;
		repeat (PressCycles) @(posedge CLK_100hz);
		#DriveDelay;
		rawControls.makeRecording_n = 1'b1;
		rawControls.playRecording_n = 1'b1;
	endtask

	task automatic waitForIdle();
		while (currentState != Idle) @(negedge CLK_100hz);
	endtask

	// Replay shows no keys at its first strobe and one entry per frame after
	task automatic compareReplay(input int recordedLength);
		checkCount("replay frames", playLog.size(), recordedLength + 1);
		for (int i = 0; i < recordedLength && i + 1 < playLog.size(); i++) begin
			checkKeys("replayed keys", playLog[i + 1], recordLog[i]);
		end
	endtask

	// Watchdog
	initial begin
		#(WatchdogTime);
		$display("Timeout: run did not finish in time, %0d errors so far", errorCount);
		$display("ERRORS FOUND");
		$finish;
	end

	//----------------------------------------------------------------------
	// Test sequence
	//----------------------------------------------------------------------
	initial begin
		keyVector pattern;
		int       keyIndex;
		void'($urandom(RandomSeed));
		repeat (ResetCycles) @(posedge CLK_100hz);
		#DriveDelay;
		systemReset_n = 1'b1;

		// Idle pins after reset
		@(negedge CLK_100hz);
		checkLevel("spiSync_n", spiSync_n, 1'b1);
		checkLevel("dacBusy", dacBusy, 1'b0);
		checkKeys("activeKeys", activeKeys, '0);
		checkState("currentState", currentState, Idle);

		// Empty playback right after reset
		playLog.delete();
		pressButton(1'b0);
		checkState("currentState", currentState, Playback);
		waitForIdle();
		repeat (2) waitFrameStart();
		checkCount("empty replay frames", playLog.size(), 1);
		foreach (playLog[i]) checkKeys("empty replay keys", playLog[i], '0);

		// Live play with random patterns
		repeat (LivePatterns) begin
			pattern = keyVector'($urandom);
			waitFrameStart();
			rawControls.musicKeys_n = ~pattern;
			repeat (2) waitFrameStart(); // Past smoothing plus a frame
			@(negedge CLK_100hz);
			checkKeys("activeKeys", activeKeys, pattern);
		end
		waitFrameStart();
		rawControls.musicKeys_n = '1;

		// Short glitch on one key
		keyIndex = $urandom % NumKeys;
		waitFrameStart();
		rawControls.musicKeys_n[keyIndex] = 1'b0;
		repeat (SmoothCycles - 1) @(posedge CLK_100hz);
		#DriveDelay;
		rawControls.musicKeys_n[keyIndex] = 1'b1;
		repeat (SmoothCycles + 6) begin
			@(negedge CLK_100hz);
			checkKeys("activeKeys after glitch", activeKeys, '0);
		end

		// Record a few patterns, stop by hand, replay
		recordLog.delete();
		pressButton(1'b1);
		checkState("currentState", currentState, Recording);
		repeat (4) begin
			waitFrameStart();
			rawControls.musicKeys_n = ~keyVector'($urandom);
			repeat (2) waitFrameStart();
		end
		pressButton(1'b1);
		rawControls.musicKeys_n = '1;
		checkState("currentState", currentState, Idle);
		repeat (2) waitFrameStart();
		if (recordLog.size() == 0 || recordLog.size() >= RecordDepth) begin
			errorCount++;
			$display("Recording stopped by hand stored %0d frames, outside 1 to %0d",
				recordLog.size(), RecordDepth - 1);
		end
		playLog.delete();
		pressButton(1'b0);
		checkState("currentState", currentState, Playback);
		waitForIdle();
		repeat (2) waitFrameStart();
		compareReplay(recordLog.size());

		// Record until the memory is full
		recordLog.delete();
		pressButton(1'b1);
		for (int i = 0; i < RecordDepth + 4 && currentState != Idle; i++) begin
			waitFrameStart();
			rawControls.musicKeys_n = ~keyVector'($urandom);
		end
		rawControls.musicKeys_n = '1;
		@(negedge CLK_100hz);
		checkState("currentState after full", currentState, Idle);
		repeat (2) waitFrameStart();
		checkCount("recorded frames", recordLog.size(), RecordDepth);
		playLog.delete();
		pressButton(1'b0);
		waitForIdle();
		repeat (2) waitFrameStart();
		compareReplay(RecordDepth);

		if (framesChecked == 0) begin
			errorCount++;
			$display("No DAC frame was decoded during the run");
		end
		$display("Summary: %0d checks, %0d frames decoded, %0d errors", checkTotal,
			framesChecked, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: musicBox.f
logic/musicBoxPkg.sv
logic/dacPkg.sv
logic/triggerSmoother.sv
logic/musicBoxStateController.sv
logic/keyRecorder.sv
logic/toneSampleGenerator.sv
logic/spiDacSerializer.sv
logic/musicBoxMain.sv
bench/musicBoxBench.sv

// File: runMusicBox.sh
#!/usr/bin/env bash
# Compile and run the music box testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module musicBoxBench -Mdir obj_dir -f musicBox.f

simOutput=$(./obj_dir/VmusicBoxBench)
echo "$simOutput"

if ! grep -qx "NO ERRORS" <<< "$simOutput"; then
	exit 1
fi
